/* all.f */
video_pkg.sv
tmds_pkg.sv
video_ctrl.sv
video_timing.sv
test_pattern.sv
tmds_encoder.sv
dvi_top.sv
dvi_top_checker.sv
tb_dvi_top.sv

/* Makefile */
TOP = tb_dvi_top
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	rm -f $(LOG)
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx '\*\* PASS \*\*' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* tb_dvi_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dvi_top
    import video_pkg::*;
    import tmds_pkg::*;
();

    // tests cover about three frames, five gives room for the handshakes
    localparam int cycle_limit = 5 * h_total * v_total;

    logic         clk_pixel;
    logic         reset;
    logic         wb_cyc;
    logic         wb_stb;
    logic         wb_we;
    logic [1:0]   wb_adr;
    logic [31:0]  wb_dat_w;
    logic [31:0]  wb_dat_r;
    logic         wb_ack;
    tmds_symbol_t tmds_red;
    tmds_symbol_t tmds_green;
    tmds_symbol_t tmds_blue;

    // register contents as written over the bus
    logic         tb_run;
    logic [1:0]   tb_pat;
    logic [23:0]  tb_solid;
    int           tb_frames;
    int           cycles;

    // position model and its two cycle delay line {run, x, y, pat, solid}
    logic         prev_run;
    int           cur_x;
    int           cur_y;
    logic [49:0]  st_d1;
    logic [49:0]  st_d2;
    logic [26:0]  want;
    logic         in_line;
    int           bal_r;
    int           bal_g;
    int           bal_b;
    logic [31:0]  rd_data;
    logic [31:0]  colour;

    dvi_top u_dvi_top (
        .clk_pixel  (clk_pixel),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .tmds_red   (tmds_red),
        .tmds_green (tmds_green),
        .tmds_blue  (tmds_blue)
    );

    always #10 clk_pixel = ~clk_pixel;

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
        @(posedge clk_pixel);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        do begin
            @(posedge clk_pixel);
            #2;
        end while (!wb_ack);
        // the write landed on the edge that raised ack
        if (adr == reg_ctrl) begin
            tb_run = data[0];
            tb_pat = data[2:1];
        end else if (adr == reg_solid) begin
            tb_solid = data[23:0];
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
        @(posedge clk_pixel);
        #2;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        do begin
            @(posedge clk_pixel);
            #2;
        end while (!wb_ack);
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic wait_pos(input int x, input int y);
        @(posedge clk_pixel);
        while ((cur_x != x) || (cur_y != y)) begin
            @(posedge clk_pixel);
        end
    endtask

    // returns {de, hsync, vsync, red, green, blue}
    function automatic logic [26:0] expected_pixel(input logic run, input int x, input int y,
                                                   input logic [1:0] pat,
                                                   input logic [23:0] solid);
        logic       de;
        logic       hs;
        logic       vs;
        logic [2:0] bar;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        de  = run && (x < h_active) && (y < v_active);
        hs  = run && (x >= h_active + h_front) && (x < h_active + h_front + h_sync);
        vs  = run && (y >= v_active + v_front) && (y < v_active + v_front + v_sync);
        bar = 3'b000;
        r   = 8'd0;
        g   = 8'd0;
        b   = 8'd0;
        if (de) begin
            case (pat)
                pat_bars: begin
                    // rgb on/off per bar
                    case (x / (h_active / 8))
                        0: bar = 3'b111;
                        1: bar = 3'b110;
                        2: bar = 3'b011;
                        3: bar = 3'b010;
                        4: bar = 3'b101;
                        5: bar = 3'b100;
                        6: bar = 3'b001;
                        default: bar = 3'b000;
                    endcase
                    r = {8{bar[2]}};
                    g = {8{bar[1]}};
                    b = {8{bar[0]}};
                end
                pat_gradient: begin
                    r = 8'(x);
                    g = 8'(y);
                    b = 8'(x + y);
                end
                pat_checker: begin
                    r = (x[5] != y[5]) ? 8'hff : 8'h00;
                    g = r;
                    b = r;
                end
                default: begin
                    r = solid[23:16];
                    g = solid[15:8];
                    b = solid[7:0];
                end
            endcase
        end
        return {de, hs, vs, r, g, b};
    endfunction

    // undo the inversion flag, then the xor or xnor chain
    function automatic logic [7:0] tmds_decode(input tmds_symbol_t sym);
        logic [7:0] q;
        logic [7:0] d;
        q    = sym[9] ? ~sym[7:0] : sym[7:0];
        d[0] = q[0];
        for (int i = 1; i < 8; i++) begin
            d[i] = sym[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
        end
        return d;
    endfunction

    function automatic tmds_symbol_t ctrl_symbol(input logic c1, input logic c0);
        case ({c1, c0})
            2'b00: return ctrl_sym_00;
            2'b01: return ctrl_sym_01;
            2'b10: return ctrl_sym_10;
            default: return ctrl_sym_11;
        endcase
    endfunction

    // lanes now must show the position held two cycles ago
    always @(negedge clk_pixel) begin
        if (!reset) begin
            want = expected_pixel(st_d2[49], int'(st_d2[48:37]), int'(st_d2[36:26]),
                                  st_d2[25:24], st_d2[23:0]);
            if (want[26]) begin
                check_eq("red", 32'(want[23:16]), 32'(tmds_decode(tmds_red)));
                check_eq("green", 32'(want[15:8]), 32'(tmds_decode(tmds_green)));
                check_eq("blue", 32'(want[7:0]), 32'(tmds_decode(tmds_blue)));
                bal_r   = bal_r + 2 * $countones(tmds_red) - 10;
                bal_g   = bal_g + 2 * $countones(tmds_green) - 10;
                bal_b   = bal_b + 2 * $countones(tmds_blue) - 10;
                in_line = 1'b1;
            end else begin
                check_eq("tmds_red", 32'(ctrl_sym_00), 32'(tmds_red));
                check_eq("tmds_green", 32'(ctrl_sym_00), 32'(tmds_green));
                check_eq("tmds_blue", 32'(ctrl_symbol(want[24], want[25])), 32'(tmds_blue));
                if (in_line) begin
                    if ((bal_r < -10) || (bal_r > 10) || (bal_g < -10) || (bal_g > 10)
                        || (bal_b < -10) || (bal_b > 10)) begin
                        $display("dc balance of a line drifted: red %0d green %0d blue %0d",
                                 bal_r, bal_g, bal_b);
                        abort_run();
                    end
                    bal_r   = 0;
                    bal_g   = 0;
                    bal_b   = 0;
                    in_line = 1'b0;
                end
            end
            // step the position model for this cycle
            if (!tb_run || !prev_run) begin
                cur_x = 0;
                cur_y = 0;
            end else if (cur_x == h_total - 1) begin
                cur_x = 0;
                if (cur_y == v_total - 1) begin
                    cur_y     = 0;
                    tb_frames = tb_frames + 1;
                end else begin
                    cur_y = cur_y + 1;
                end
            end else begin
                cur_x = cur_x + 1;
            end
            prev_run = tb_run;
            st_d2    = st_d1;
            st_d1    = {tb_run, 12'(cur_x), 11'(cur_y), tb_pat, tb_solid};
        end
    end

    always @(posedge clk_pixel) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: test sequence still running after %0d cycles", cycles);
            abort_run();
        end
    end

    initial begin
        clk_pixel = 1'b0;
        reset     = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = 2'd0;
        wb_dat_w  = 32'd0;
        tb_run    = 1'b0;
        tb_pat    = 2'd0;
        tb_solid  = 24'd0;
        tb_frames = 0;
        cycles    = 0;
        prev_run  = 1'b0;
        cur_x     = 0;
        cur_y     = 0;
        st_d1     = '0;
        st_d2     = '0;
        in_line   = 1'b0;
        bal_r     = 0;
        bal_g     = 0;
        bal_b     = 0;
        void'($urandom(91));
        repeat (2) @(posedge clk_pixel);
        #2;
        reset = 1'b0;

        // register readback, output stays blank
        wb_read(reg_frames, rd_data);
        check_eq("frames", 32'd0, rd_data);
        wb_write(reg_ctrl, 32'h6);
        wb_read(reg_ctrl, rd_data);
        check_eq("ctrl", 32'h6, rd_data);
        colour = $urandom() & 32'h00ff_ffff;
        wb_write(reg_solid, colour);
        wb_read(reg_solid, rd_data);
        check_eq("solid", colour, rd_data);
        wb_read(2'd3, rd_data);
        check_eq("unused", 32'd0, rd_data);

        // one full frame of bars
        wb_write(reg_ctrl, 32'h1);
        wait_pos(100, v_active + 20);
        wait_pos(100, 2);
        wb_read(reg_frames, rd_data);
        check_eq("frames", 32'(tb_frames), rd_data);

        // gradient then checker within one frame
        wb_write(reg_ctrl, 32'h3);
        wait_pos(100, 300);
        wb_write(reg_ctrl, 32'h5);
        wait_pos(100, v_active + 20);
        wait_pos(100, 2);
        wb_read(reg_frames, rd_data);
        check_eq("frames", 32'(tb_frames), rd_data);

        // three random solid colours, a third of a frame each
        wb_write(reg_ctrl, 32'h7);
        for (int i = 1; i <= 3; i++) begin
            colour = $urandom() & 32'h00ff_ffff;
            wb_write(reg_solid, colour);
            wait_pos(100, i * 190);
        end
        wait_pos(100, 2);
        wb_read(reg_frames, rd_data);
        check_eq("frames", 32'(tb_frames), rd_data);

        // disable, then restart from (0,0) with bars
        wb_write(reg_ctrl, 32'h6);
        repeat (h_total) @(posedge clk_pixel);
        wb_read(reg_frames, rd_data);
        check_eq("frames", 32'(tb_frames), rd_data);
        wb_write(reg_ctrl, 32'h1);
        wait_pos(100, 3);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* dvi_top_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module dvi_top_checker
    import tmds_pkg::*;
(
    input logic         clk_pixel,
    input logic         reset,
    input logic         wb_cyc,
    input logic         wb_stb,
    input logic         wb_ack,
    input logic         de,
    input tmds_symbol_t tmds_red,
    input tmds_symbol_t tmds_green,
    input tmds_symbol_t tmds_blue,
    input disparity_t   disp_red,
    input disparity_t   disp_green,
    input disparity_t   disp_blue
);

    logic de_q;

    // lanes carry the de of one cycle earlier
    always_ff @(posedge clk_pixel) begin
        if (reset) begin
            de_q <= 1'b0;
        end else begin
            de_q <= de;
        end
    end

    // bit 8 must match the xor/xnor choice the decoded data calls for
    function automatic logic flag_ok(input tmds_symbol_t sym);
        logic [7:0] q;
        logic [7:0] d;
        int         ones;
        q    = sym[9] ? ~sym[7:0] : sym[7:0];
        d[0] = q[0];
        for (int i = 1; i < 8; i++) begin
            d[i] = sym[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
        end
        ones = $countones(d);
        return sym[8] == !((ones > 4) || ((ones == 4) && !d[0]));
    endfunction

    function automatic logic lane_ok(input tmds_symbol_t sym, input logic video);
        return video ? flag_ok(sym)
                     : (sym inside {ctrl_sym_00, ctrl_sym_01, ctrl_sym_10, ctrl_sym_11});
    endfunction

    // a new request is acked on the next clock, for exactly one cycle
    a_ack_single: assert property (@(posedge clk_pixel) disable iff (reset)
        $rose(wb_cyc && wb_stb) |=> wb_ack ##1 !wb_ack)
        else $error("wb_ack not a single cycle one clock after the request");

    a_ack_after_stb: assert property (@(posedge clk_pixel) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without a strobe in the cycle before");

    a_lanes: assert property (@(posedge clk_pixel) disable iff (reset)
        lane_ok(tmds_red, de_q) && lane_ok(tmds_green, de_q) && lane_ok(tmds_blue, de_q))
        else $error("tmds symbol does not fit the current period");

    a_disparity: assert property (@(posedge clk_pixel) disable iff (reset)
        (disp_red >= -5'sd8) && (disp_red <= 5'sd8)
        && (disp_green >= -5'sd8) && (disp_green <= 5'sd8)
        && (disp_blue >= -5'sd8) && (disp_blue <= 5'sd8))
        else $error("running disparity left the -8 to +8 range");

endmodule

bind dvi_top dvi_top_checker u_checker (
    .clk_pixel  (clk_pixel),
    .reset      (reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_ack     (wb_ack),
    .de         (de),
    .tmds_red   (tmds_red),
    .tmds_green (tmds_green),
    .tmds_blue  (tmds_blue),
    .disp_red   (u_enc_red.disp_q),
    .disp_green (u_enc_green.disp_q),
    .disp_blue  (u_enc_blue.disp_q)
);

`default_nettype wire

/* dvi_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dvi_top
    import video_pkg::*;
    import tmds_pkg::*;
(
    input  logic         clk_pixel,
    input  logic         reset,
    input  logic         wb_cyc,
    input  logic         wb_stb,
    input  logic         wb_we,
    input  logic [1:0]   wb_adr,
    input  logic [31:0]  wb_dat_w,
    output logic [31:0]  wb_dat_r,
    output logic         wb_ack,
    output tmds_symbol_t tmds_red,
    output tmds_symbol_t tmds_green,
    output tmds_symbol_t tmds_blue
);

    logic        run;
    pattern_t    pattern_sel;
    logic [23:0] solid_rgb;
    coord_x_t    pos_x;
    coord_y_t    pos_y;
    logic        hsync;
    logic        vsync;
    logic        active;
    logic        frame_start;
    color_t      red;
    color_t      green;
    color_t      blue;
    logic        de;
    logic        pix_hsync;
    logic        pix_vsync;

    video_ctrl u_ctrl (
        .clk_pixel   (clk_pixel),
        .reset       (reset),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .frame_start (frame_start),
        .run         (run),
        .pattern_sel (pattern_sel),
        .solid_rgb   (solid_rgb)
    );

    video_timing u_timing (
        .clk_pixel   (clk_pixel),
        .reset       (reset),
        .run         (run),
        .pos_x       (pos_x),
        .pos_y       (pos_y),
        .hsync       (hsync),
        .vsync       (vsync),
        .active      (active),
        .frame_start (frame_start)
    );

    test_pattern u_pattern (
        .clk_pixel   (clk_pixel),
        .reset       (reset),
        .pos_x       (pos_x),
        .pos_y       (pos_y),
        .active      (active),
        .hsync       (hsync),
        .vsync       (vsync),
        .pattern_sel (pattern_sel),
        .solid_rgb   (solid_rgb),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .de          (de),
        .hsync_out   (pix_hsync),
        .vsync_out   (pix_vsync)
    );

    // red and green carry no control bits
    tmds_encoder u_enc_red (
        .clk_pixel (clk_pixel),
        .reset     (reset),
        .data      (red),
        .c0        (1'b0),
        .c1        (1'b0),
        .de        (de),
        .symbol    (tmds_red)
    );

    tmds_encoder u_enc_green (
        .clk_pixel (clk_pixel),
        .reset     (reset),
        .data      (green),
        .c0        (1'b0),
        .c1        (1'b0),
        .de        (de),
        .symbol    (tmds_green)
    );

    // syncs ride on the blue lane
    tmds_encoder u_enc_blue (
        .clk_pixel (clk_pixel),
        .reset     (reset),
        .data      (blue),
        .c0        (pix_hsync),
        .c1        (pix_vsync),
        .de        (de),
        .symbol    (tmds_blue)
    );

endmodule

`default_nettype wire

/* tmds_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module tmds_encoder
    import video_pkg::*;
    import tmds_pkg::*;
(
    input  logic         clk_pixel,
    input  logic         reset,
    input  color_t       data,
    input  logic         c0,
    input  logic         c1,
    input  logic         de,
    output tmds_symbol_t symbol
);

    logic [3:0]   n1_data;
    logic [3:0]   n1_qm;
    logic         use_xnor;
    logic [8:0]   q_m;
    disparity_t   balance;
    disparity_t   disp_q;
    disparity_t   disp_cur;
    disparity_t   disp_next;
    tmds_symbol_t video_sym;
    tmds_symbol_t ctrl_sym;
    enc_mode_t    mode;

    always_comb begin
        n1_data = '0;
        for (int i = 0; i < 8; i++) begin
            n1_data = n1_data + 4'(data[i]);
        end
    end

    // transition minimisation
    assign use_xnor = (n1_data > 4'd4) || ((n1_data == 4'd4) && !data[0]);

    always_comb begin
        q_m[0] = data[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
        end
        q_m[8] = ~use_xnor;
    end

    always_comb begin
        n1_qm = '0;
        for (int i = 0; i < 8; i++) begin
            n1_qm = n1_qm + 4'(q_m[i]);
        end
    end

    // ones minus zeros of the 8 data bits
    assign balance = disparity_t'({n1_qm, 1'b0}) - disparity_t'(8);

    // a control period leaves the running disparity at zero
    assign disp_cur = (mode == enc_video) ? disp_q : '0;

    always_comb begin
        if ((disp_cur == 0) || (balance == 0)) begin
            video_sym = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disp_next = q_m[8] ? disp_cur + balance : disp_cur - balance;
        end else if (((disp_cur > 0) && (balance > 0)) || ((disp_cur < 0) && (balance < 0))) begin
            // invert to pull back towards zero
            video_sym = {1'b1, q_m[8], ~q_m[7:0]};
            disp_next = disp_cur + disparity_t'({q_m[8], 1'b0}) - balance;
        end else begin
            video_sym = {1'b0, q_m[8], q_m[7:0]};
            disp_next = disp_cur - disparity_t'({~q_m[8], 1'b0}) + balance;
        end
    end

    always_comb begin
        case ({c1, c0})
            2'b00: begin
                ctrl_sym = ctrl_sym_00;
            end
            2'b01: begin
                ctrl_sym = ctrl_sym_01;
            end
            2'b10: begin
                ctrl_sym = ctrl_sym_10;
            end
            default: begin
                ctrl_sym = ctrl_sym_11;
            end
        endcase
    end

    always_ff @(posedge clk_pixel) begin
        if (reset) begin
            symbol <= ctrl_sym_00;
            disp_q <= '0;
            mode   <= enc_control;
        end else if (de) begin
            symbol <= video_sym;
            disp_q <= disp_next;
            mode   <= enc_video;
        end else begin
            symbol <= ctrl_sym;
            mode   <= enc_control;
        end
    end

endmodule

`default_nettype wire

/* test_pattern.sv */
`timescale 1ns/1ps
`default_nettype none

module test_pattern
    import video_pkg::*;
(
    input  logic        clk_pixel,
    input  logic        reset,
    input  coord_x_t    pos_x,
    input  coord_y_t    pos_y,
    input  logic        active,
    input  logic        hsync,
    input  logic        vsync,
    input  pattern_t    pattern_sel,
    input  logic [23:0] solid_rgb,
    output color_t      red,
    output color_t      green,
    output color_t      blue,
    output logic        de,
    output logic        hsync_out,
    output logic        vsync_out
);

    logic [2:0] bar_idx;
    coord_x_t   diag;
    color_t     pix_r;
    color_t     pix_g;
    color_t     pix_b;

    // which 90 pixel bar the position falls in
    always_comb begin
        bar_idx = '0;
        for (int i = 1; i < 8; i++) begin
            if (pos_x >= coord_x_t'(i * bar_width)) begin
                bar_idx = 3'(i);
            end
        end
    end

    assign diag = pos_x + coord_x_t'(pos_y);

    always_comb begin
        pix_r = '0;
        pix_g = '0;
        pix_b = '0;
        if (active) begin
            case (pattern_sel)
                pat_bars: begin
                    // white yellow cyan green magenta red blue black
                    pix_r = {8{~bar_idx[1]}};
                    pix_g = {8{~bar_idx[2]}};
                    pix_b = {8{~bar_idx[0]}};
                end
                pat_gradient: begin
                    pix_r = pos_x[7:0];
                    pix_g = pos_y[7:0];
                    pix_b = diag[7:0];
                end
                pat_checker: begin
                    pix_r = {8{pos_x[5] ^ pos_y[5]}};
                    pix_g = {8{pos_x[5] ^ pos_y[5]}};
                    pix_b = {8{pos_x[5] ^ pos_y[5]}};
                end
                default: begin
                    pix_r = solid_rgb[23:16];
                    pix_g = solid_rgb[15:8];
                    pix_b = solid_rgb[7:0];
                end
            endcase
        end
    end

    always_ff @(posedge clk_pixel) begin
        red   <= pix_r;
        green <= pix_g;
        blue  <= pix_b;
    end

    // sync and de delayed to match the colour stage
    always_ff @(posedge clk_pixel) begin
        if (reset) begin
            de        <= 1'b0;
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
        end else begin
            de        <= active;
            hsync_out <= hsync;
            vsync_out <= vsync;
        end
    end

endmodule

`default_nettype wire

/* video_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module video_timing
    import video_pkg::*;
(
    input  logic     clk_pixel,
    input  logic     reset,
    input  logic     run,
    output coord_x_t pos_x,
    output coord_y_t pos_y,
    output logic     hsync,
    output logic     vsync,
    output logic     active,
    output logic     frame_start
);

    coord_x_t next_x;
    coord_y_t next_y;
    logic     last_x;
    logic     last_y;
    logic     active_q;
    logic     hsync_q;
    logic     vsync_q;
    logic     wrap_q;

    assign last_x = (pos_x == coord_x_t'(h_total - 1));
    assign last_y = (pos_y == coord_y_t'(v_total - 1));

    // counters sit at (0,0) while stopped
    always_comb begin
        next_x = '0;
        next_y = '0;
        if (run) begin
            if (last_x) begin
                next_y = last_y ? '0 : pos_y + 1'b1;
            end else begin
                next_x = pos_x + 1'b1;
                next_y = pos_y;
            end
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (reset) begin
            pos_x    <= '0;
            pos_y    <= '0;
            active_q <= 1'b0;
            hsync_q  <= 1'b0;
            vsync_q  <= 1'b0;
            wrap_q   <= 1'b0;
        end else begin
            pos_x <= next_x;
            pos_y <= next_y;
            // windows decoded from the next position so they line up with pos
            active_q <= (next_x < coord_x_t'(h_active)) && (next_y < coord_y_t'(v_active));
            hsync_q  <= (next_x >= coord_x_t'(h_sync_start))
                     && (next_x < coord_x_t'(h_sync_end));
            vsync_q  <= (next_y >= coord_y_t'(v_sync_start))
                     && (next_y < coord_y_t'(v_sync_end));
            wrap_q   <= run && last_x && last_y;
        end
    end

    // stop takes effect at once, counters follow next clock
    assign active      = active_q && run;
    assign hsync       = hsync_q && run;
    assign vsync       = vsync_q && run;
    assign frame_start = wrap_q && run;

endmodule

`default_nettype wire

/* video_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module video_ctrl
    import video_pkg::*;
(
    input  logic        clk_pixel,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    input  logic        frame_start,
    output logic        run,
    output pattern_t    pattern_sel,
    output logic [23:0] solid_rgb
);

    frame_count_t frame_count;
    logic         access;
    logic [31:0]  read_mux;

    // new cycle seen, ack not yet given
    assign access = wb_cyc && wb_stb && !wb_ack;

    always_comb begin
        case (wb_adr)
            reg_ctrl: begin
                read_mux = {29'd0, pattern_sel, run};
            end
            reg_solid: begin
                read_mux = {8'd0, solid_rgb};
            end
            reg_frames: begin
                read_mux = {16'd0, frame_count};
            end
            default: begin
                read_mux = '0;
            end
        endcase
    end

    // single cycle ack, write lands on the same edge
    always_ff @(posedge clk_pixel) begin
        if (reset) begin
            wb_ack      <= 1'b0;
            run         <= 1'b0;
            pattern_sel <= pat_bars;
            solid_rgb   <= '0;
        end else begin
            wb_ack <= access;
            if (access && wb_we) begin
                case (wb_adr)
                    reg_ctrl: begin
                        run         <= wb_dat_w[0];
                        pattern_sel <= pattern_t'(wb_dat_w[2:1]);
                    end
                    reg_solid: begin
                        solid_rgb <= wb_dat_w[23:0];
                    end
                    default: begin
                        // frames is read only
                    end
                endcase
            end
        end
    end

    // read data held for the ack cycle
    always_ff @(posedge clk_pixel) begin
        if (access) begin
            wb_dat_r <= read_mux;
        end
    end

    // wraps at 16 bits
    always_ff @(posedge clk_pixel) begin
        if (reset) begin
            frame_count <= '0;
        end else if (frame_start) begin
            frame_count <= frame_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* tmds_pkg.sv */
`default_nettype none

package tmds_pkg;

    typedef logic [9:0]        tmds_symbol_t;
    typedef logic signed [4:0] disparity_t;

    // control symbols indexed by {c1, c0}
    localparam tmds_symbol_t ctrl_sym_00 = 10'b1101010100;
    localparam tmds_symbol_t ctrl_sym_01 = 10'b0010101011;
    localparam tmds_symbol_t ctrl_sym_10 = 10'b0101010100;
    localparam tmds_symbol_t ctrl_sym_11 = 10'b1010101011;

    // period the encoder was in on the previous cycle
    typedef enum logic {
        enc_control,
        enc_video
    } enc_mode_t;

endpackage

`default_nettype wire

/* video_pkg.sv */
`default_nettype none

package video_pkg;

    // 720x576 progressive, 27 MHz pixel clock
    localparam int h_active = 720;
    localparam int h_front  = 12;
    localparam int h_sync   = 64;
    localparam int h_back   = 68;
    localparam int h_sync_start = h_active + h_front;
    localparam int h_sync_end   = h_sync_start + h_sync;
    localparam int h_total      = h_sync_end + h_back;

    localparam int v_active = 576;
    localparam int v_front  = 5;
    localparam int v_sync   = 5;
    localparam int v_back   = 39;
    localparam int v_sync_start = v_active + v_front;
    localparam int v_sync_end   = v_sync_start + v_sync;
    localparam int v_total      = v_sync_end + v_back;

    // eight bars across the active line
    localparam int bar_width = h_active / 8;

    // wishbone word addresses
    localparam logic [1:0] reg_ctrl   = 2'd0;
    localparam logic [1:0] reg_solid  = 2'd1;
    localparam logic [1:0] reg_frames = 2'd2;

    typedef logic [11:0] coord_x_t;
    typedef logic [10:0] coord_y_t;
    typedef logic [7:0]  color_t;
    typedef logic [15:0] frame_count_t;

    typedef enum logic [1:0] {
        pat_bars,
        pat_gradient,
        pat_checker,
        pat_solid
    } pattern_t;

endpackage

`default_nettype wire
